// File: Makefile
SIM = obj_dir/Vmulti_adc_tb
SOURCES = $(shell cat project.f)

all: run

$(SIM): project.f $(SOURCES)
	verilator --binary --timing --assert -f project.f --top-module multi_adc_tb -o Vmulti_adc_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: project.f
src/adc_timing_pkg.sv
src/adc_bus_pkg.sv
src/adc_csr.sv
src/adc_sequencer.sv
src/adc_word_chain.sv
src/multi_adc_top.sv
tests/multi_adc_asserts.sv
tests/multi_adc_checker.sv
tests/multi_adc_tb.sv

// File: src/adc_bus_pkg.sv
// APB register map, APB structs, ADC pin bundle and output sample type of the ADC capture block
package adc_bus_pkg;

   // width of the output sample word, ADC data is left justified in it
   localparam int sample_bits = 32;
   // the drop counter saturates at its all ones value
   localparam int drop_bits = 16;

   // register offsets on the APB bus
   localparam logic [3:0] ctrl_offset = 4'h0;
   localparam logic [3:0] cfg_offset = 4'h4;
   localparam logic [3:0] drop_offset = 4'h8;

   typedef logic [drop_bits-1:0] drop_count_t;

   typedef struct packed {
      logic psel;
      logic penable;
      logic pwrite;
      logic [3:0] paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic pready;
      logic pslverr;
   } apb_rsp_t;

   // pins driven in common to all ADCs
   typedef struct packed {
      logic mclk;
      logic scka;
      logic sync;
      logic sdi;
   } adc_pins_t;

   typedef struct packed {
      logic valid;
      logic [sample_bits-1:0] data;
   } sample_t;

endpackage

// File: src/adc_csr.sv
// APB register block holding the capture enable, the ADC configuration word and the drop count
module adc_csr (
   input  logic capture_clk,
   input  logic is_reset,
   input  adc_bus_pkg::apb_req_t apb_req,
   output adc_bus_pkg::apb_rsp_t apb_rsp,
   input  logic drop,
   output logic enable,
   output adc_timing_pkg::config_word_t cfg_word
);

   // the access phase of a transfer, psel and penable both high
   logic access;
   logic write_en;
   adc_bus_pkg::drop_count_t drop_count;

   assign access = apb_req.psel && apb_req.penable;
   assign write_en = access && apb_req.pwrite;

   // writes land on the clock edge that closes the access phase
   always_ff @(posedge capture_clk) begin
      if (is_reset) begin
         enable <= 1'b0;
         cfg_word <= '0;
         drop_count <= '0;
      end else begin
         if (write_en && apb_req.paddr == adc_bus_pkg::ctrl_offset) begin
            enable <= apb_req.pwdata[0];
         end
         if (write_en && apb_req.paddr == adc_bus_pkg::cfg_offset) begin
            cfg_word <= apb_req.pwdata[adc_timing_pkg::config_bits-1:0];
         end
         // a write of any value clears the count, and wins over a drop in the same cycle
         if (write_en && apb_req.paddr == adc_bus_pkg::drop_offset) begin
            drop_count <= '0;
         end else if (drop && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
         end
      end
   end

   // read data is decoded straight from the registers during the access phase
   always_comb begin
      apb_rsp.prdata = '0;
      apb_rsp.pready = 1'b1;
      apb_rsp.pslverr = 1'b0;
      case (apb_req.paddr)
         adc_bus_pkg::ctrl_offset: begin
            apb_rsp.prdata[0] = enable;
         end
         adc_bus_pkg::cfg_offset: begin
            apb_rsp.prdata[adc_timing_pkg::config_bits-1:0] = cfg_word;
         end
         adc_bus_pkg::drop_offset: begin
            apb_rsp.prdata[adc_bus_pkg::drop_bits-1:0] = drop_count;
         end
         default: begin
            // unmapped offsets answer with an error, reads return zero
            apb_rsp.pslverr = access;
         end
      endcase
   end

endmodule

// File: src/adc_sequencer.sv
// conversion sequencer generating MCLK, SCKA, SYNC and SDI for all ADCs plus the shift strobe
module adc_sequencer (
   input  logic capture_clk,
   input  logic is_reset,
   input  logic enable,
   input  adc_timing_pkg::config_word_t cfg_word,
   input  logic load_done,
   output logic shift_ena,
   output logic seq_idle,
   output adc_bus_pkg::adc_pins_t adc_pins
);

   adc_timing_pkg::seq_state_t state;
   adc_timing_pkg::seq_mode_t mode;
   // position in the conversion cycle, the state and the pins lag it by one and two clocks
   adc_timing_pkg::cycle_t adc_cycle;
   adc_timing_pkg::decimate_t decimate_count;
   adc_timing_pkg::config_word_t config_shift;
   adc_timing_pkg::config_count_t config_count;
   // high while the scka pin carries configuration clocks, aligned with the pins
   logic config_phase;
   logic in_reset;
   logic in_config;
   logic in_start;
   logic in_convert;
   logic in_sync;
   logic in_acquire;
   logic convert_end;
   logic sync_end;
   logic acquire_end;
   logic wait_end;
   logic config_end;
   // the next capture_clk edge would be a rising edge of scka, scka is high on odd cycles
   logic scka_positive;
   logic sdi_next;

   assign in_reset = (state == adc_timing_pkg::reset_state);
   assign in_config = (state == adc_timing_pkg::config_state);
   assign in_start = (state == adc_timing_pkg::start_state);
   assign in_convert = (state == adc_timing_pkg::convert_state);
   assign in_sync = (state == adc_timing_pkg::sync_state);
   assign in_acquire = (state == adc_timing_pkg::acquire_state);

   assign convert_end = (adc_cycle == adc_timing_pkg::convert_last);
   assign sync_end = (adc_cycle == adc_timing_pkg::sync_last);
   assign acquire_end = (adc_cycle == adc_timing_pkg::acquire_last);
   assign wait_end = (adc_cycle == adc_timing_pkg::wait_last);
   assign scka_positive = ~adc_cycle[0];
   // configuration is over on the falling scka edge of its last bit
   assign config_end = in_config && adc_pins.scka && (config_count == adc_timing_pkg::config_last);

   // a configuration clock is not a data clock, the data shifters only follow scka and sync
   assign shift_ena = (adc_pins.scka && !config_phase) || adc_pins.sync;

   always_ff @(posedge capture_clk) begin
      if (is_reset || in_reset || wait_end) begin
         adc_cycle <= '0;
      end else begin
         adc_cycle <= adc_cycle + 1'b1;
      end
   end

   // the counter starts at zero so that the first start state opens a full decimation period
   always_ff @(posedge capture_clk) begin
      if (is_reset || in_reset) begin
         decimate_count <= '0;
         mode <= adc_timing_pkg::sync_mode;
      end else if (in_start) begin
         if (decimate_count == '0) begin
            decimate_count <= adc_timing_pkg::decimate_last;
            mode <= adc_timing_pkg::sync_mode;
         end else begin
            decimate_count <= decimate_count - 1'b1;
         end
      end else if (load_done) begin
         mode <= adc_timing_pkg::wait_mode;
      end else if (in_acquire && mode == adc_timing_pkg::sync_mode) begin
         // sync mode is held into the first acquire cycle to swallow one scka pulse
         mode <= adc_timing_pkg::acquire_mode;
      end
   end

   // the configuration word is reloaded whenever the sequencer is outside config state
   always_ff @(posedge capture_clk) begin
      if (!in_config) begin
         config_shift <= cfg_word;
         config_count <= '0;
      end else if (adc_pins.scka) begin
         config_shift <= config_shift << 1;
         config_count <= config_count + 1'b1;
      end
   end

   // sdi moves on the falling scka edge so it is stable at each rising edge
   always_comb begin
      sdi_next = 1'b0;
      if (in_config && !config_end) begin
         if (adc_pins.scka) begin
            sdi_next = config_shift[adc_timing_pkg::config_bits-2];
         end else begin
            sdi_next = config_shift[adc_timing_pkg::config_bits-1];
         end
      end
   end

   always_ff @(posedge capture_clk) begin
      if (is_reset || !enable) begin
         state <= adc_timing_pkg::reset_state;
      end else begin
         case (state)
            adc_timing_pkg::reset_state: state <= adc_timing_pkg::config_state;
            // after configuration wait for the cycle counter to wrap before converting
            adc_timing_pkg::config_state: begin
               if (config_end) state <= adc_timing_pkg::wait_state;
            end
            adc_timing_pkg::start_state: state <= adc_timing_pkg::convert_state;
            // once the whole word is read the sync window and acquisition are skipped
            adc_timing_pkg::convert_state: begin
               if (convert_end) begin
                  if (mode == adc_timing_pkg::wait_mode) begin
                     state <= adc_timing_pkg::wait_state;
                  end else begin
                     state <= adc_timing_pkg::sync_state;
                  end
               end
            end
            adc_timing_pkg::sync_state: begin
               if (sync_end) state <= adc_timing_pkg::acquire_state;
            end
            adc_timing_pkg::acquire_state: begin
               if (acquire_end && wait_end) begin
                  state <= adc_timing_pkg::start_state;
               end else if (acquire_end) begin
                  state <= adc_timing_pkg::wait_state;
               end
            end
            adc_timing_pkg::wait_state: begin
               if (wait_end) state <= adc_timing_pkg::start_state;
            end
            default: state <= adc_timing_pkg::reset_state;
         endcase
      end
   end

   // every pin is a flop so no runt pulses reach the ADCs
   always_ff @(posedge capture_clk) begin
      if (is_reset) begin
         adc_pins <= '{mclk: 1'b0, scka: 1'b0, sync: 1'b1, sdi: 1'b0};
         seq_idle <= 1'b1;
         config_phase <= 1'b0;
      end else begin
         // the first config slot is skipped so sdi settles before the first rising edge
         adc_pins.scka <= scka_positive && ((in_acquire && mode != adc_timing_pkg::sync_mode)
                                            || (in_config && adc_cycle != '0));
         adc_pins.mclk <= in_start || in_convert;
         adc_pins.sync <= in_reset
                          || (in_sync && mode == adc_timing_pkg::sync_mode && scka_positive);
         adc_pins.sdi <= sdi_next;
         seq_idle <= in_reset;
         config_phase <= in_config;
      end
   end

endmodule

// File: src/adc_timing_pkg.sv
// conversion timing, word widths and sequencer types shared by the ADC capture logic and its tests
package adc_timing_pkg;

   // number of ADCs read in parallel, bit 0 of the sdoa bus is channel 0
   localparam int adc_channels = 4;
   // bits in one decimated output word of each ADC
   localparam int adc_bits = 24;
   // capture_clk cycles in one MCLK conversion cycle
   localparam int adc_cycles = 32;
   // MCLK stays high for the conversion time of the ADC
   localparam int convert_cycles = 10;
   // distributed read, only this many SPI bits are clocked per conversion
   localparam int acquire_nbits = 3;
   // conversions per decimated word, adc_decimate * acquire_nbits must equal adc_bits
   localparam int adc_decimate = 8;
   // length of the SPI configuration word sent on SDI after enable
   localparam int config_bits = 12;
   // the cycle counter must hold adc_cycles - 1
   localparam int cycle_width = 5;

   typedef logic [cycle_width-1:0] cycle_t;
   // last cycle of MCLK high time
   localparam cycle_t convert_last = cycle_t'(convert_cycles - 1);
   // one SPI bit period (two clocks) after the conversion is kept for SYNC
   localparam cycle_t sync_last = cycle_t'(convert_cycles + 1);
   // each SPI bit takes two capture_clk cycles
   localparam cycle_t acquire_last = cycle_t'(convert_cycles + 1 + 2 * acquire_nbits);
   localparam cycle_t wait_last = cycle_t'(adc_cycles - 1);

   typedef logic [$clog2(adc_bits)-1:0] bit_count_t;
   localparam bit_count_t bit_last = bit_count_t'(adc_bits - 1);
   typedef logic [$clog2(adc_decimate)-1:0] decimate_t;
   localparam decimate_t decimate_last = decimate_t'(adc_decimate - 1);
   typedef logic [config_bits-1:0] config_word_t;
   typedef logic [$clog2(config_bits)-1:0] config_count_t;
   localparam config_count_t config_last = config_count_t'(config_bits - 1);

   typedef enum logic [2:0] {
      reset_state, config_state, start_state, convert_state, sync_state, acquire_state, wait_state
   } seq_state_t;
   // outer mode, tracks where the sequencer is within one decimated word
   typedef enum logic [1:0] {acquire_mode, wait_mode, sync_mode} seq_mode_t;

endpackage

// File: src/adc_word_chain.sv
// per-channel SDOA shifters and the output chain that presents one left-justified word per clock
module adc_word_chain (
   input  logic capture_clk,
   input  logic is_reset,
   input  logic seq_idle,
   input  logic [adc_timing_pkg::adc_channels-1:0] adc_sdoa,
   input  logic shift_ena,
   input  logic capture_full,
   output logic load_done,
   output logic drop,
   output adc_bus_pkg::sample_t sample
);

   // input shift registers, one per ADC, MSB arrives first
   logic [adc_timing_pkg::adc_bits-1:0] shift_reg [adc_timing_pkg::adc_channels];
   // counts down to the bit that completes the word
   adc_timing_pkg::bit_count_t bit_count;
   // chain[0] is the word on the output, the far end fills with zeros
   adc_bus_pkg::sample_t chain [adc_timing_pkg::adc_channels];

   always_ff @(posedge capture_clk) begin
      if (shift_ena) begin
         for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
            shift_reg[c] <= {shift_reg[c][adc_timing_pkg::adc_bits-2:0], adc_sdoa[c]};
         end
      end
   end

   // the counter restarts with the sequencer so the first sync shift is always the MSB
   always_ff @(posedge capture_clk) begin
      if (is_reset || seq_idle) begin
         bit_count <= adc_timing_pkg::bit_last;
         load_done <= 1'b0;
      end else if (shift_ena && bit_count == '0) begin
         bit_count <= adc_timing_pkg::bit_last;
         load_done <= 1'b1;
      end else begin
         if (shift_ena) bit_count <= bit_count - 1'b1;
         load_done <= 1'b0;
      end
   end

   // all channels load at once, then move one stage per clock whether or not they are taken
   always_ff @(posedge capture_clk) begin
      if (is_reset || seq_idle) begin
         for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
            chain[c].valid <= 1'b0;
         end
      end else if (load_done) begin
         for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
            chain[c].valid <= 1'b1;
            chain[c].data <= {shift_reg[c],
                              {(adc_bus_pkg::sample_bits - adc_timing_pkg::adc_bits){1'b0}}};
         end
      end else begin
         for (int c = 0; c < adc_timing_pkg::adc_channels - 1; c++) begin
            chain[c] <= chain[c+1];
         end
         chain[adc_timing_pkg::adc_channels-1] <= '0;
      end
   end

   assign sample = chain[0];
   // a word shown while the sink is full is gone after this clock
   assign drop = chain[0].valid && capture_full;

endmodule

// File: src/multi_adc_top.sv
// top level of the multi ADC capture block, joining the APB registers, sequencer and word chain
module multi_adc_top (
   input  logic capture_clk,
   input  logic is_reset,
   input  adc_bus_pkg::apb_req_t apb_req,
   output adc_bus_pkg::apb_rsp_t apb_rsp,
   input  logic [adc_timing_pkg::adc_channels-1:0] adc_sdoa,
   output adc_bus_pkg::adc_pins_t adc_pins,
   input  logic capture_full,
   output adc_bus_pkg::sample_t sample
);

   // enable takes the place of a file-open signal and holds the sequencer in reset when low
   logic enable;
   adc_timing_pkg::config_word_t cfg_word;
   logic drop;
   logic shift_ena;
   logic seq_idle;
   logic load_done;

   adc_csr i_adc_csr (
      .capture_clk(capture_clk), .is_reset(is_reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .drop(drop), .enable(enable), .cfg_word(cfg_word)
   );

   adc_sequencer i_adc_sequencer (
      .capture_clk(capture_clk), .is_reset(is_reset), .enable(enable), .cfg_word(cfg_word),
      .load_done(load_done), .shift_ena(shift_ena), .seq_idle(seq_idle), .adc_pins(adc_pins)
   );

   // load_done returns to the sequencer to end acquisition for the current word
   adc_word_chain i_adc_word_chain (
      .capture_clk(capture_clk), .is_reset(is_reset), .seq_idle(seq_idle),
      .adc_sdoa(adc_sdoa), .shift_ena(shift_ena), .capture_full(capture_full),
      .load_done(load_done), .drop(drop), .sample(sample)
   );

endmodule

// File: tests/multi_adc_asserts.sv
// concurrent assertions bound into the capture top level, covering the ADC pins and the output
module multi_adc_asserts (
   input logic capture_clk,
   input logic is_reset,
   input adc_bus_pkg::adc_pins_t adc_pins,
   input adc_bus_pkg::sample_t sample
);

   // conversion and data clocking never overlap on the ADC pins
   mclk_scka_apart: assert property (@(posedge capture_clk) disable iff (is_reset)
      !(adc_pins.mclk && adc_pins.scka))
      else $error("mclk and scka were high in the same cycle");

   // the ADCs see sync held while the block is in reset
   sync_in_reset: assert property (@(posedge capture_clk) is_reset |=> adc_pins.sync)
      else $error("sync was low during reset");

   valid_in_reset: assert property (@(posedge capture_clk) is_reset |=> !sample.valid)
      else $error("sample valid was high during reset");

endmodule

// File: tests/multi_adc_checker.sv
// monitor beside the DUT that models registers, ADC words and pin timing and checks its ports
module multi_adc_checker (
   input  logic capture_clk,
   input  logic is_reset,
   input  adc_bus_pkg::apb_req_t apb_req,
   input  adc_bus_pkg::apb_rsp_t apb_rsp,
   input  adc_bus_pkg::adc_pins_t adc_pins,
   input  adc_bus_pkg::sample_t sample,
   input  logic capture_full,
   input  logic [adc_timing_pkg::adc_channels*adc_timing_pkg::adc_bits-1:0] model_words,
   input  logic model_push,
   input  logic model_flush,
   input  int test_num,
   input  logic test_done,
   output int error_count,
   output int accepted_count,
   output int dropped_count
);

   logic [adc_timing_pkg::adc_bits-1:0] expected_q [$];
   logic enable_model;
   logic [adc_timing_pkg::config_bits-1:0] cfg_model;
   logic [adc_bus_pkg::drop_bits-1:0] drop_model;
   logic [31:0] expected_data;
   logic expected_err;
   logic [adc_timing_pkg::config_bits-1:0] sdi_word;
   int sdi_count;
   logic configuring;
   logic prev_scka;
   logic prev_mclk;
   logic have_rise;
   int since_rise;
   int high_count;
   int disable_wait;
   int test_errors;

   initial begin
      error_count = 0;
      accepted_count = 0;
      dropped_count = 0;
      test_errors = 0;
      configuring = 1'b0;
      have_rise = 1'b0;
      sdi_count = 0;
      sdi_word = '0;
      since_rise = 0;
      high_count = 0;
      prev_scka = 1'b0;
      prev_mclk = 1'b0;
   end

   task automatic count_error();
      error_count++;
      test_errors++;
   endtask

   always @(posedge capture_clk) begin
      if (is_reset) begin
         enable_model = 1'b0;
         cfg_model = '0;
         drop_model = '0;
         disable_wait = 0;
      end else begin
         // after enable is cleared the pins must settle within one conversion cycle
         if (disable_wait != 0) begin
            if (adc_pins.sync && !adc_pins.mclk && !adc_pins.scka && !adc_pins.sdi
                && !sample.valid) begin
               disable_wait = 0;
            end else if (disable_wait == 1) begin
               $display("outputs did not return to reset values after enable was cleared");
               count_error();
               disable_wait = 0;
            end else begin
               disable_wait--;
            end
         end
         // every access completes in its first access cycle, there are no wait states
         if (apb_req.psel && apb_req.penable && apb_rsp.pready !== 1'b1) begin
            $display("mismatch pready: got %h expected %h", apb_rsp.pready, 1'b1);
            count_error();
         end
         if (apb_req.psel && apb_req.penable && !apb_req.pwrite) begin
            expected_err = 1'b0;
            case (apb_req.paddr)
               adc_bus_pkg::ctrl_offset: expected_data = {31'b0, enable_model};
               adc_bus_pkg::cfg_offset: expected_data = 32'(cfg_model);
               adc_bus_pkg::drop_offset: expected_data = 32'(drop_model);
               default: begin
                  expected_data = '0;
                  expected_err = 1'b1;
               end
            endcase
            if (apb_rsp.prdata !== expected_data) begin
               $display("mismatch prdata at offset %h: got %h expected %h", apb_req.paddr,
                        apb_rsp.prdata, expected_data);
               count_error();
            end
            if (apb_rsp.pslverr !== expected_err) begin
               $display("mismatch pslverr at offset %h: got %h expected %h", apb_req.paddr,
                        apb_rsp.pslverr, expected_err);
               count_error();
            end
         end
         // the counter clear wins over a drop in the same cycle
         if (apb_req.psel && apb_req.penable && apb_req.pwrite
             && apb_req.paddr == adc_bus_pkg::drop_offset) begin
            drop_model = '0;
         end else if (sample.valid && capture_full && drop_model != '1) begin
            drop_model = drop_model + 1'b1;
         end
         if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
            if (apb_req.paddr == adc_bus_pkg::ctrl_offset) begin
               if (enable_model && !apb_req.pwdata[0]) disable_wait = adc_timing_pkg::adc_cycles;
               enable_model = apb_req.pwdata[0];
            end
            if (apb_req.paddr == adc_bus_pkg::cfg_offset) begin
               cfg_model = apb_req.pwdata[adc_timing_pkg::config_bits-1:0];
            end
         end
         // a word shown while the sink is full is lost, so its model word is skipped
         if (sample.valid) begin
            if (expected_q.size() == 0) begin
               $display("a valid sample appeared with no model word waiting");
               count_error();
            end else begin
               expected_data = 32'(expected_q.pop_front())
                               << (adc_bus_pkg::sample_bits - adc_timing_pkg::adc_bits);
               if (capture_full) begin
                  dropped_count++;
               end else begin
                  accepted_count++;
                  if (sample.data !== expected_data) begin
                     $display("mismatch sample.data: got %h expected %h",
                              sample.data, expected_data);
                     count_error();
                  end
               end
            end
         end
         // the configuration word is taken at the scka rising edges before the first mclk
         if (configuring && adc_pins.scka && !prev_scka) begin
            sdi_word = {sdi_word[adc_timing_pkg::config_bits-2:0], adc_pins.sdi};
            sdi_count++;
         end
         if (adc_pins.mclk && !prev_mclk) begin
            if (configuring
                && (sdi_count != adc_timing_pkg::config_bits || sdi_word !== cfg_model)) begin
               $display("mismatch sdi: got %h in %0d bits expected %h", sdi_word, sdi_count,
                        cfg_model);
               count_error();
            end
            configuring = 1'b0;
            if (have_rise && since_rise != adc_timing_pkg::adc_cycles) begin
               $display("mismatch mclk period: got %h expected %h", since_rise,
                        adc_timing_pkg::adc_cycles);
               count_error();
            end
            have_rise = 1'b1;
            since_rise = 0;
            high_count = 0;
         end
         if (adc_pins.mclk) high_count++;
         // a high time cut short by clearing enable is not a conversion
         if (enable_model && !adc_pins.mclk && prev_mclk
             && high_count != adc_timing_pkg::convert_cycles) begin
            $display("mismatch mclk high time: got %h expected %h", high_count,
                     adc_timing_pkg::convert_cycles);
            count_error();
         end
         since_rise++;
      end
      // the ADC model restarts while the sequencer is held in reset
      if (model_flush) begin
         expected_q.delete();
         configuring = 1'b1;
         sdi_count = 0;
         have_rise = 1'b0;
      end
      // a completed word set queues in channel order
      if (model_push) begin
         for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
            expected_q.push_back(
               model_words[c*adc_timing_pkg::adc_bits +: adc_timing_pkg::adc_bits]);
         end
      end
      if (test_done) begin
         $display("test %0d finished with %0d errors", test_num, test_errors);
         test_errors = 0;
      end
      prev_scka = (adc_pins.scka === 1'b1);
      prev_mclk = (adc_pins.mclk === 1'b1);
   end

endmodule

// File: tests/multi_adc_tb.sv
// testbench top for the multi ADC capture block, drives APB, the ADC data lines and back-pressure
module multi_adc_tb;

   localparam int word_timeout = 4000;
   localparam int set_bits = adc_timing_pkg::adc_channels * adc_timing_pkg::adc_bits;

   logic capture_clk;
   logic is_reset;
   adc_bus_pkg::apb_req_t apb_req;
   adc_bus_pkg::apb_rsp_t apb_rsp;
   logic [adc_timing_pkg::adc_channels-1:0] adc_sdoa;
   adc_bus_pkg::adc_pins_t adc_pins;
   logic capture_full;
   adc_bus_pkg::sample_t sample;
   logic [set_bits-1:0] model_words;
   logic model_push;
   logic model_flush;
   int test_num;
   logic test_done;
   int error_count;
   int accepted_count;
   int dropped_count;
   logic [31:0] lfsr_state;
   logic full_random;
   logic sync_prev;
   logic mclk_seen;
   int bit_index;
   logic [adc_timing_pkg::adc_bits-1:0] adc_words [adc_timing_pkg::adc_channels];
   logic [31:0] value;

   multi_adc_top i_multi_adc_top (
      .capture_clk(capture_clk), .is_reset(is_reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .adc_sdoa(adc_sdoa), .adc_pins(adc_pins), .capture_full(capture_full), .sample(sample)
   );

   multi_adc_checker i_multi_adc_checker (
      .capture_clk(capture_clk), .is_reset(is_reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .adc_pins(adc_pins), .sample(sample), .capture_full(capture_full),
      .model_words(model_words), .model_push(model_push), .model_flush(model_flush),
      .test_num(test_num), .test_done(test_done), .error_count(error_count),
      .accepted_count(accepted_count), .dropped_count(dropped_count)
   );

   bind multi_adc_top multi_adc_asserts i_multi_adc_asserts (
      .capture_clk(capture_clk), .is_reset(is_reset), .adc_pins(adc_pins), .sample(sample)
   );

   initial begin
      capture_clk = 1'b0;
      forever #20 capture_clk = ~capture_clk;
   end

   // Galois LFSR, one step for every bit handed out
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++) begin
         bits = {bits[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
      end
      return bits;
   endfunction

   // a fresh word per ADC, its MSB goes out at once so the sync shift takes it
   task automatic draw_words();
      logic [31:0] word;
      logic [adc_timing_pkg::adc_channels-1:0] msbs;
      for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
         word = random_bits(adc_timing_pkg::adc_bits);
         adc_words[c] = word[adc_timing_pkg::adc_bits-1:0];
         msbs[c] = word[adc_timing_pkg::adc_bits-1];
      end
      adc_sdoa <= msbs;
   endtask

   // ADC model, every shift clock that ends moves all channels to their next bit
   always @(posedge capture_clk) begin
      capture_full <= full_random && (random_bits(2) == 32'd3);
      model_push <= 1'b0;
      model_flush <= 1'b0;
      if (adc_pins.sync === 1'b1 && sync_prev) begin
         // sync held for more than one clock means the sequencer is in reset
         mclk_seen = 1'b0;
         bit_index = 0;
         draw_words();
         model_flush <= 1'b1;
      end else if (mclk_seen && (adc_pins.sync === 1'b1 || adc_pins.scka === 1'b1)) begin
         bit_index++;
         if (bit_index == adc_timing_pkg::adc_bits) begin
            for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
               model_words[c*adc_timing_pkg::adc_bits +: adc_timing_pkg::adc_bits] <= adc_words[c];
            end
            model_push <= 1'b1;
            bit_index = 0;
            draw_words();
         end else begin
            for (int c = 0; c < adc_timing_pkg::adc_channels; c++) begin
               adc_sdoa[c] <= adc_words[c][adc_timing_pkg::adc_bits-1-bit_index];
            end
         end
      end
      if (adc_pins.mclk === 1'b1) mclk_seen = 1'b1;
      sync_prev = (adc_pins.sync === 1'b1);
   end

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      $display("Verification failed");
      $finish;
   endtask

   // one APB transfer, setup cycle then access cycle
   task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] data);
      @(posedge capture_clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
      @(posedge capture_clk);
      apb_req.penable <= 1'b1;
      @(posedge capture_clk);
      apb_req <= '0;
   endtask

   task automatic wait_words(input int target, input logic count_drops);
      int cycles;
      int seen;
      cycles = 0;
      seen = accepted_count + (count_drops ? dropped_count : 0);
      while (seen < target && cycles < word_timeout) begin
         @(posedge capture_clk);
         cycles++;
         seen = accepted_count + (count_drops ? dropped_count : 0);
      end
      if (seen < target) report_timeout("sample words did not arrive in time");
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (!(adc_pins.sync && !adc_pins.mclk && !adc_pins.scka && !sample.valid)
             && cycles < adc_timing_pkg::adc_cycles + 4) begin
         @(posedge capture_clk);
         cycles++;
      end
      if (!adc_pins.sync || sample.valid) report_timeout("outputs stayed active after disable");
   endtask

   task automatic end_test(input int number);
      @(posedge capture_clk);
      test_num <= number;
      test_done <= 1'b1;
      @(posedge capture_clk);
      test_done <= 1'b0;
   endtask

   initial begin
      lfsr_state = 32'h54fda9ed;
      is_reset = 1'b1;
      apb_req = '0;
      adc_sdoa = '0;
      capture_full = 1'b0;
      full_random = 1'b0;
      model_words = '0;
      model_push = 1'b0;
      model_flush = 1'b0;
      test_num = 0;
      test_done = 1'b0;
      sync_prev = 1'b0;
      mclk_seen = 1'b0;
      bit_index = 0;
      repeat (16) @(posedge capture_clk);
      is_reset <= 1'b0;
      // registers read back what was written, enable kept low
      for (int i = 0; i < 4; i++) begin
         @(negedge capture_clk);
         value = random_bits(32);
         apb_access(1'b1, adc_bus_pkg::cfg_offset, value);
         apb_access(1'b0, adc_bus_pkg::cfg_offset, '0);
         @(negedge capture_clk);
         value = random_bits(32);
         apb_access(1'b1, adc_bus_pkg::ctrl_offset, {value[31:1], 1'b0});
         apb_access(1'b0, adc_bus_pkg::ctrl_offset, '0);
      end
      apb_access(1'b0, 4'hc, '0);
      end_test(1);
      @(negedge capture_clk);
      value = random_bits(adc_timing_pkg::config_bits);
      apb_access(1'b1, adc_bus_pkg::cfg_offset, value);
      apb_access(1'b1, adc_bus_pkg::ctrl_offset, 32'h1);
      wait_words(12, 1'b0);
      end_test(2);
      // back-pressure, then the drop count is read and cleared
      full_random <= 1'b1;
      wait_words(accepted_count + dropped_count + 24, 1'b1);
      full_random <= 1'b0;
      apb_access(1'b0, adc_bus_pkg::drop_offset, '0);
      apb_access(1'b1, adc_bus_pkg::drop_offset, 32'h5);
      apb_access(1'b0, adc_bus_pkg::drop_offset, '0);
      end_test(3);
      apb_access(1'b1, adc_bus_pkg::ctrl_offset, 32'h0);
      wait_idle();
      repeat (2 * adc_timing_pkg::adc_cycles) @(posedge capture_clk);
      @(negedge capture_clk);
      value = random_bits(adc_timing_pkg::config_bits);
      apb_access(1'b1, adc_bus_pkg::cfg_offset, value);
      apb_access(1'b1, adc_bus_pkg::ctrl_offset, 32'h1);
      wait_words(accepted_count + 12, 1'b0);
      end_test(4);
      repeat (2) @(posedge capture_clk);
      @(negedge capture_clk);
      $display("totals: %0d accepted, %0d dropped, %0d errors",
               accepted_count, dropped_count, error_count);
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
